//--- hdl/mac_settings.svh
`ifndef MAC_SETTINGS_SVH
`define MAC_SETTINGS_SVH

// frame buffer size in bytes
`define MAC_BUF_DEPTH 512

// preamble bytes ahead of the SFD
`define MAC_PREAMBLE_LEN 2

// deferral timing, in slot ticks
`define MAC_DIFS_TICKS 80
`define MAC_SIFS_TICKS 40
`define MAC_SLOT_TICKS 8
`define MAC_ACK_TIMEOUT 256

// retransmissions before the error count rises
`define MAC_MAX_ATTEMPTS 5
`define MAC_MAX_PAYLOAD 255

// fixed frame bytes
`define MAC_PREAMBLE_BYTE 8'h55
`define MAC_SFD_BYTE 8'hD0

// frame type codes
`define MAC_FT_NOCRC 8'h30
`define MAC_FT_ACKREQ 8'h32
`define MAC_FT_ACK 8'h33

`endif

//--- hdl/mac_pkg.sv
package mac_pkg;

    // one frame or host byte
    typedef logic [7:0] mac_byte_t;

    // frame buffer address
    typedef logic [8:0] buf_addr_t;

    // where the next buffered byte comes from
    typedef enum logic [2:0] {
        SRC_PREAMBLE,
        SRC_SFD,
        SRC_DEST,
        SRC_ACK_DEST,
        SRC_MAC,
        SRC_FTYPE,
        SRC_ACK_FTYPE,
        SRC_HOST
    } byte_src_t;

    // controller orders to the mux and the buffer
    typedef struct packed {
        logic      write_en;
        logic      read_en;
        buf_addr_t write_address;
        buf_addr_t read_address;
        byte_src_t byte_src;
    } buf_ctrl_t;

    // controller orders to the CRC block
    typedef struct packed {
        logic clear;
        logic update;
        logic transmit;
    } crc_ctrl_t;

endpackage

//--- hdl/frame_buffer.sv
`timescale 1ns/1ps
`include "mac_settings.svh"

module frame_buffer import mac_pkg::*; (
    input  logic      clk,
    input  buf_ctrl_t buf_ctrl,
    input  mac_byte_t wr_data,
    output mac_byte_t rd_data
);

    mac_byte_t mem [`MAC_BUF_DEPTH];

    always_ff @(posedge clk) begin
        if (buf_ctrl.write_en)
            mem[buf_ctrl.write_address] <= wr_data;
    end

    // one cycle read latency, holds between reads
    always_ff @(posedge clk) begin
        if (buf_ctrl.read_en)
            rd_data <= mem[buf_ctrl.read_address];
    end

endmodule

//--- hdl/frame_mux.sv
`timescale 1ns/1ps
`include "mac_settings.svh"

module frame_mux import mac_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  buf_ctrl_t buf_ctrl,
    input  mac_byte_t host_data,
    input  mac_byte_t mac_addr,
    input  mac_byte_t ack_frame_addr,
    output mac_byte_t wr_data,
    output mac_byte_t frame_type
);

    mac_byte_t host_q;

    // host byte lines up with the registered write order
    always_ff @(posedge clk) begin
        host_q <= host_data;
    end

    always_comb begin
        case (buf_ctrl.byte_src)
            SRC_PREAMBLE:  wr_data = `MAC_PREAMBLE_BYTE;
            SRC_SFD:       wr_data = `MAC_SFD_BYTE;
            SRC_ACK_DEST:  wr_data = ack_frame_addr;
            SRC_MAC:       wr_data = mac_addr;
            SRC_ACK_FTYPE: wr_data = `MAC_FT_ACK;
            default:       wr_data = host_q;
        endcase
    end

    // frame type kept for the controller's CRC and ack decisions
    always_ff @(posedge clk) begin
        if (rst)
            frame_type <= '0;
        else if (buf_ctrl.write_en && buf_ctrl.byte_src == SRC_FTYPE)
            frame_type <= host_q;
        else if (buf_ctrl.write_en && buf_ctrl.byte_src == SRC_ACK_FTYPE)
            frame_type <= `MAC_FT_ACK;
    end

endmodule

//--- hdl/crc_gen.sv
`timescale 1ns/1ps

module crc_gen import mac_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  crc_ctrl_t crc_ctrl,
    input  mac_byte_t rd_data,
    output mac_byte_t tx_data
);

    mac_byte_t crc_q;

    // CRC-8, polynomial x^8 + x^2 + x + 1, msb first
    function automatic mac_byte_t crc8_byte(input mac_byte_t crc, input mac_byte_t data);
        mac_byte_t c;
        c = crc ^ data;
        for (int i = 0; i < 8; i++) begin
            if (c[7])
                c = (c << 1) ^ 8'h07;
            else
                c = c << 1;
        end
        return c;
    endfunction

    always_ff @(posedge clk) begin
        if (rst || crc_ctrl.clear)
            crc_q <= '0;
        else if (crc_ctrl.update)
            crc_q <= crc8_byte(crc_q, rd_data);
    end

    // buffer byte, or the check byte at frame end
    assign tx_data = crc_ctrl.transmit ? crc_q : rd_data;

    a_clr_upd: assert property (@(posedge clk) disable iff (rst)
        !(crc_ctrl.clear && crc_ctrl.update));

endmodule

//--- hdl/xmit_controller.sv
`timescale 1ns/1ps
`include "mac_settings.svh"

module xmit_controller import mac_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       tick_slot,
    input  logic       tick_tx,
    input  logic       xvalid,
    input  logic       xsend,
    input  logic       mx_rdy,
    input  logic       cardet,
    input  logic       ack_received,
    input  logic       ack_needed,
    input  mac_byte_t  frame_type,
    output buf_ctrl_t  buf_ctrl,
    output crc_ctrl_t  crc_ctrl,
    output logic       mx_valid,
    output logic       xrdy,
    output logic       xbusy,
    output logic       ack_sent,
    output logic [7:0] xerrcnt
);

    localparam buf_addr_t PRE = buf_addr_t'(`MAC_PREAMBLE_LEN);

    typedef enum logic [3:0] {
        IDLE, LOAD_PREAMBLE, LOAD_SFD, LOAD_DEST, LOAD_SRC, LOAD_FTYPE,
        LOAD_PAYLOAD, WAIT_DIFS, WAIT_BACKOFF, TRANSMIT, TRANSMIT_CRC, ACK_WAIT
    } state_t;

    state_t    state, state_next;

    // registered write order, one cycle behind the decision
    logic      wr_en_q;
    buf_addr_t wr_addr_q;
    byte_src_t src_q;

    buf_addr_t wr_ptr, wr_ptr_next, rd_ptr;
    logic [7:0] plen;
    logic [8:0] timer, bo_last;
    logic [4:0] backoff;
    logic [2:0] attempts;
    logic [3:0] rnd;
    logic       ack_mode;
    logic       crc_upd_q, crc_tx_q;

    logic      wr_req;
    byte_src_t wr_src;
    buf_addr_t wr_at;
    logic      rd_go, rd_rst, start_tx;
    logic      tmr_clr, tmr_inc, bo_load;
    logic      att_inc, err_inc, ack_set, ack_done, send_crc, plen_inc;

    // backoff length in slot ticks
    assign bo_last = 9'(backoff * `MAC_SLOT_TICKS) - 9'd1;

    always_comb begin
        state_next = state;
        wr_req     = 1'b0;
        wr_src     = SRC_HOST;
        wr_at      = wr_ptr;
        wr_ptr_next = wr_ptr;
        rd_go      = 1'b0;
        rd_rst     = 1'b0;
        start_tx   = 1'b0;
        tmr_clr    = 1'b0;
        tmr_inc    = 1'b0;
        bo_load    = 1'b0;
        att_inc    = 1'b0;
        err_inc    = 1'b0;
        ack_set    = 1'b0;
        ack_done   = 1'b0;
        send_crc   = 1'b0;
        plen_inc   = 1'b0;
        case (state)
            IDLE: begin
                wr_ptr_next = '0;
                rd_rst      = 1'b1;
                tmr_clr     = 1'b1;
                if (ack_needed && !ack_sent) begin
                    ack_set    = 1'b1;
                    state_next = LOAD_PREAMBLE;
                end else if (xvalid) begin
                    // host destination goes straight to its slot
                    wr_req     = 1'b1;
                    wr_src     = SRC_DEST;
                    wr_at      = PRE + 9'd1;
                    state_next = LOAD_PREAMBLE;
                end
            end
            LOAD_PREAMBLE: begin
                wr_req      = 1'b1;
                wr_src      = SRC_PREAMBLE;
                wr_ptr_next = wr_ptr + 9'd1;
                if (wr_ptr == PRE - 9'd1)
                    state_next = LOAD_SFD;
            end
            LOAD_SFD: begin
                wr_req = 1'b1;
                wr_src = SRC_SFD;
                if (ack_mode) begin
                    wr_ptr_next = wr_ptr + 9'd1;
                    state_next  = LOAD_DEST;
                end else begin
                    // skip the destination already written
                    wr_ptr_next = wr_ptr + 9'd2;
                    state_next  = LOAD_SRC;
                end
            end
            LOAD_DEST: begin
                wr_req      = 1'b1;
                wr_src      = SRC_ACK_DEST;
                wr_ptr_next = wr_ptr + 9'd1;
                state_next  = LOAD_SRC;
            end
            LOAD_SRC: begin
                wr_req      = 1'b1;
                wr_src      = SRC_MAC;
                wr_ptr_next = wr_ptr + 9'd1;
                state_next  = LOAD_FTYPE;
            end
            LOAD_FTYPE: begin
                if (ack_mode) begin
                    wr_req      = 1'b1;
                    wr_src      = SRC_ACK_FTYPE;
                    wr_ptr_next = wr_ptr + 9'd1;
                    state_next  = WAIT_DIFS;
                end else if (xvalid) begin
                    wr_req      = 1'b1;
                    wr_src      = SRC_FTYPE;
                    wr_ptr_next = wr_ptr + 9'd1;
                    state_next  = LOAD_PAYLOAD;
                end
            end
            LOAD_PAYLOAD: begin
                if (xvalid) begin
                    wr_req      = 1'b1;
                    wr_src      = SRC_HOST;
                    wr_ptr_next = wr_ptr + 9'd1;
                    plen_inc    = 1'b1;
                end
                if (xsend || (xvalid && plen == 8'(`MAC_MAX_PAYLOAD - 1)))
                    state_next = WAIT_DIFS;
            end
            WAIT_DIFS: begin
                if (tick_slot) begin
                    if (timer == 9'(`MAC_DIFS_TICKS - 1)) begin
                        tmr_clr = 1'b1;
                        if (cardet) begin
                            bo_load    = 1'b1;
                            state_next = WAIT_BACKOFF;
                        end else begin
                            start_tx   = 1'b1;
                            state_next = TRANSMIT;
                        end
                    end else begin
                        tmr_inc = 1'b1;
                    end
                end
            end
            WAIT_BACKOFF: begin
                if (tick_slot) begin
                    if (timer == bo_last) begin
                        tmr_clr = 1'b1;
                        if (cardet) begin
                            // still busy, draw a fresh backoff
                            bo_load = 1'b1;
                        end else begin
                            start_tx   = 1'b1;
                            state_next = TRANSMIT;
                        end
                    end else begin
                        tmr_inc = 1'b1;
                    end
                end
            end
            TRANSMIT: begin
                if (cardet) begin
                    tmr_clr    = 1'b1;
                    state_next = WAIT_DIFS;
                end else if (tick_tx && mx_rdy) begin
                    rd_go = 1'b1;
                    if (rd_ptr == wr_ptr - 9'd1) begin
                        if (frame_type != `MAC_FT_NOCRC)
                            state_next = TRANSMIT_CRC;
                        else
                            state_next = IDLE;
                    end
                end
            end
            TRANSMIT_CRC: begin
                if (tick_tx && mx_rdy && !cardet) begin
                    send_crc = 1'b1;
                    if (ack_mode) begin
                        ack_done   = 1'b1;
                        state_next = IDLE;
                    end else if (frame_type == `MAC_FT_ACKREQ) begin
                        tmr_clr    = 1'b1;
                        state_next = ACK_WAIT;
                    end else begin
                        state_next = IDLE;
                    end
                end
            end
            ACK_WAIT: begin
                if (tick_slot) begin
                    if (timer == 9'(`MAC_ACK_TIMEOUT - 1)) begin
                        tmr_clr = 1'b1;
                        if (ack_received) begin
                            state_next = IDLE;
                        end else if (attempts == 3'(`MAC_MAX_ATTEMPTS)) begin
                            err_inc    = 1'b1;
                            state_next = IDLE;
                        end else begin
                            att_inc    = 1'b1;
                            state_next = WAIT_DIFS;
                        end
                    end else begin
                        tmr_inc = 1'b1;
                    end
                end
            end
            default: state_next = IDLE;
        endcase
    end

    // free-running backoff source
    always_ff @(posedge clk) begin
        if (rst)
            rnd <= '0;
        else
            rnd <= rnd + 4'd1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            wr_en_q   <= 1'b0;
            wr_addr_q <= '0;
            src_q     <= SRC_PREAMBLE;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            plen      <= '0;
            timer     <= '0;
            backoff   <= 5'd1;
            attempts  <= '0;
            xerrcnt   <= '0;
            ack_mode  <= 1'b0;
            mx_valid  <= 1'b0;
            crc_upd_q <= 1'b0;
            crc_tx_q  <= 1'b0;
            ack_sent  <= 1'b0;
        end else begin
            state     <= state_next;
            wr_en_q   <= wr_req;
            wr_addr_q <= wr_at;
            src_q     <= wr_src;
            wr_ptr    <= wr_ptr_next;
            mx_valid  <= rd_go || send_crc;
            // only destination through payload feed the CRC
            crc_upd_q <= rd_go && (rd_ptr > PRE);
            crc_tx_q  <= send_crc;
            ack_sent  <= ack_done;
            if (rd_rst || start_tx)
                rd_ptr <= '0;
            else if (rd_go)
                rd_ptr <= rd_ptr + 9'd1;
            if (state == IDLE)
                plen <= '0;
            else if (plen_inc)
                plen <= plen + 8'd1;
            if (tmr_clr)
                timer <= '0;
            else if (tmr_inc)
                timer <= timer + 9'd1;
            if (bo_load)
                backoff <= {1'b0, rnd} + 5'd1;
            if (state == IDLE)
                attempts <= '0;
            else if (att_inc)
                attempts <= attempts + 3'd1;
            if (err_inc)
                xerrcnt <= xerrcnt + 8'd1;
            if (ack_set)
                ack_mode <= 1'b1;
            else if (state == IDLE)
                ack_mode <= 1'b0;
        end
    end

    always_comb begin
        buf_ctrl.write_en      = wr_en_q;
        buf_ctrl.read_en       = rd_go;
        buf_ctrl.write_address = wr_addr_q;
        buf_ctrl.read_address  = rd_ptr;
        buf_ctrl.byte_src      = src_q;
        crc_ctrl.clear         = start_tx;
        crc_ctrl.update        = crc_upd_q;
        crc_ctrl.transmit      = crc_tx_q;
    end

    assign xbusy = (state != IDLE);
    assign xrdy  = (state == IDLE && !ack_needed)
                || ((state == LOAD_FTYPE || state == LOAD_PAYLOAD) && !ack_mode);

    a_wr_rd_excl: assert property (@(posedge clk) disable iff (rst)
        !(buf_ctrl.write_en && buf_ctrl.read_en));

    // a sent byte follows a qualifying cycle outside IDLE
    a_valid_src: assert property (@(posedge clk) disable iff (rst)
        mx_valid |-> $past(xbusy && tick_tx && mx_rdy && !cardet));

    a_wr_bound: assert property (@(posedge clk) disable iff (rst)
        int'(wr_ptr) <= `MAC_PREAMBLE_LEN + 4 + `MAC_MAX_PAYLOAD);

endmodule

//--- hdl/mac_xmit.sv
`timescale 1ns/1ps

module mac_xmit import mac_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       tick_slot,
    input  logic       tick_tx,
    input  mac_byte_t  host_data,
    input  logic       xvalid,
    input  logic       xsend,
    input  logic       mx_rdy,
    input  logic       cardet,
    input  logic       ack_received,
    input  logic       ack_needed,
    input  mac_byte_t  ack_frame_addr,
    input  mac_byte_t  mac_addr,
    output mac_byte_t  tx_data,
    output logic       mx_valid,
    output logic       xrdy,
    output logic       xbusy,
    output logic       ack_sent,
    output logic [7:0] xerrcnt
);

    buf_ctrl_t buf_ctrl;
    crc_ctrl_t crc_ctrl;
    mac_byte_t wr_data;
    mac_byte_t rd_data;
    mac_byte_t frame_type;

    xmit_controller u_ctrl (
        .clk(clk), .rst(rst),
        .tick_slot(tick_slot), .tick_tx(tick_tx),
        .xvalid(xvalid), .xsend(xsend), .mx_rdy(mx_rdy), .cardet(cardet),
        .ack_received(ack_received), .ack_needed(ack_needed),
        .frame_type(frame_type),
        .buf_ctrl(buf_ctrl), .crc_ctrl(crc_ctrl),
        .mx_valid(mx_valid), .xrdy(xrdy), .xbusy(xbusy),
        .ack_sent(ack_sent), .xerrcnt(xerrcnt)
    );

    frame_mux u_mux (
        .clk(clk), .rst(rst), .buf_ctrl(buf_ctrl),
        .host_data(host_data), .mac_addr(mac_addr), .ack_frame_addr(ack_frame_addr),
        .wr_data(wr_data), .frame_type(frame_type)
    );

    frame_buffer u_buf (
        .clk(clk), .buf_ctrl(buf_ctrl), .wr_data(wr_data), .rd_data(rd_data)
    );

    crc_gen u_crc (
        .clk(clk), .rst(rst), .crc_ctrl(crc_ctrl), .rd_data(rd_data), .tx_data(tx_data)
    );

endmodule

//--- test/xmit_checker.sv
`timescale 1ns/1ps
`include "mac_settings.svh"

module xmit_checker import mac_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         mx_valid,
    input  mac_byte_t    tx_data,
    input  logic         cardet,
    input  logic         ack_sent,
    input  logic [7:0]   xerrcnt,
    input  mac_byte_t    mac_addr,
    input  logic         test_start,
    input  logic         test_end,
    input  int           test_id,
    input  mac_byte_t    exp_dest,
    input  mac_byte_t    exp_ftype,
    input  int           exp_len,
    input  logic [383:0] exp_payload,
    input  int           exp_sends,
    input  int           exp_acks,
    input  logic [7:0]   exp_err_inc,
    output int           tests_done,
    output int           tests_failed,
    output int           error_total
);

    mac_byte_t  exp_q[$];
    int         idx;
    int         test_errors;
    int         ack_count;
    logic [7:0] errcnt_start;

    // poly 0x07, one data bit at a time, msb first
    function automatic mac_byte_t crc8_serial(input mac_byte_t crc, input mac_byte_t data);
        logic fb;
        for (int b = 7; b >= 0; b--) begin
            fb  = crc[7] ^ data[b];
            crc = {crc[6:0], 1'b0} ^ (fb ? 8'h07 : 8'h00);
        end
        return crc;
    endfunction

    task automatic build_expected();
        mac_byte_t frame[$];
        mac_byte_t crc;
        crc = 8'h00;
        for (int i = 0; i < `MAC_PREAMBLE_LEN; i++)
            frame.push_back(`MAC_PREAMBLE_BYTE);
        frame.push_back(`MAC_SFD_BYTE);
        frame.push_back(exp_dest);
        frame.push_back(mac_addr);
        frame.push_back(exp_ftype);
        for (int i = 0; i < exp_len; i++)
            frame.push_back(exp_payload[8*i +: 8]);
        // destination through payload
        for (int i = `MAC_PREAMBLE_LEN + 1; i < frame.size(); i++)
            crc = crc8_serial(crc, frame[i]);
        if (exp_ftype != `MAC_FT_NOCRC)
            frame.push_back(crc);
        exp_q.delete();
        // retransmissions repeat the frame unchanged
        for (int n = 0; n < exp_sends; n++) begin
            foreach (frame[i])
                exp_q.push_back(frame[i]);
        end
    endtask

    task automatic report_error(input string msg);
        $display("%s", msg);
        test_errors++;
        error_total++;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            tests_done   = 0;
            tests_failed = 0;
            error_total  = 0;
            test_errors  = 0;
            ack_count    = 0;
            idx          = 0;
        end else begin
            if (test_start) begin
                build_expected();
                idx          = 0;
                test_errors  = 0;
                ack_count    = 0;
                errcnt_start = xerrcnt;
            end
            if (mx_valid) begin
                if (cardet)
                    report_error("byte sent while the carrier was busy");
                if (idx >= exp_q.size())
                    report_error($sformatf("extra byte %h after the expected frames", tx_data));
                else if (tx_data !== exp_q[idx])
                    report_error($sformatf("** Error tx_data: byte %0d expected %h got %h",
                        idx, exp_q[idx], tx_data));
                idx++;
            end
            if (ack_sent)
                ack_count++;
            if (test_end) begin
                if (idx != exp_q.size())
                    report_error($sformatf("%0d bytes sent where %0d were expected",
                        idx, exp_q.size()));
                if (ack_count != exp_acks)
                    report_error($sformatf("ack_sent pulsed %0d times where %0d were expected",
                        ack_count, exp_acks));
                if (xerrcnt !== errcnt_start + exp_err_inc)
                    report_error($sformatf("** Error xerrcnt: expected %h got %h",
                        errcnt_start + exp_err_inc, xerrcnt));
                tests_done++;
                if (test_errors != 0)
                    tests_failed++;
                $display("test %0d: %0d bytes, %0d errors, %s", test_id, idx, test_errors,
                    (test_errors == 0) ? "ok" : "FAIL");
            end
        end
    end

endmodule

//--- test/tb_mac_xmit.sv
`timescale 1ns/1ps
`include "mac_settings.svh"

module tb_mac_xmit import mac_pkg::*; ();

    localparam int MAX_TESTS = 16;
    localparam int HOLD_BUSY = 600;
    // largest backoff in slot ticks
    localparam int BACKOFF_MAX = 16 * `MAC_SLOT_TICKS;

    logic         clk, rst, tick_slot, tick_tx, xvalid, xsend, mx_rdy, cardet;
    logic         ack_received, ack_needed, mx_valid, xrdy, xbusy, ack_sent;
    mac_byte_t    host_data, ack_frame_addr, mac_addr, tx_data;
    logic [7:0]   xerrcnt;

    // handed to the checker at test start
    logic         test_start, test_end;
    int           test_id, exp_len, exp_sends, exp_acks;
    mac_byte_t    exp_dest, exp_ftype;
    logic [7:0]   exp_err_inc;
    logic [383:0] exp_payload;
    int           tests_done, tests_failed, error_total;

    mac_byte_t    rec_kind[MAX_TESTS], rec_dest[MAX_TESTS], rec_ftype[MAX_TESTS];
    logic         rec_busy[MAX_TESTS], rec_ack[MAX_TESTS];
    int           rec_len[MAX_TESTS];
    logic [383:0] rec_pay[MAX_TESTS];
    int           n_tests, budget, tb_errors, cyc;
    logic [15:0]  lfsr;
    logic         rdy_random;
    mac_byte_t    rdy_bit;

    mac_xmit uut (.*);

    xmit_checker tx_check (.*);

    always #10 clk = ~clk;

    // tick strobes and modulator ready, driven after each edge
    always @(posedge clk) begin
        #2;
        cyc       = cyc + 1;
        tick_tx   = 1'b1;
        tick_slot = (cyc % 4 == 0);
        if (rdy_random) begin
            take_bits(1, rdy_bit);
            mx_rdy = rdy_bit[0];
        end else begin
            mx_rdy = 1'b1;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output mac_byte_t v);
        v = 8'h00;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[6:0], lfsr[0]};
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_reset_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error %s: expected %h got %h", name, exp, got);
            tb_errors++;
        end
    endtask

    task automatic read_records();
        int               fd;
        logic [8*128-1:0] line;
        mac_byte_t        f[14];
        mac_byte_t        v;
        fd = $fopen("test/xmit_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/xmit_input.txt, no tests run");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1],
                        f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12],
                        f[13]) == 14 && n_tests < MAX_TESTS) begin
                    rec_kind[n_tests]  = f[0];
                    rec_dest[n_tests]  = f[1];
                    rec_ftype[n_tests] = f[2];
                    rec_busy[n_tests]  = f[4][0];
                    rec_ack[n_tests]   = f[5][0];
                    rec_pay[n_tests]   = '0;
                    if (f[3] == 8'hff) begin
                        take_bits(6, v);
                        rec_len[n_tests] = int'(v) % 40 + 1;
                        for (int k = 0; k < rec_len[n_tests]; k++) begin
                            take_bits(8, v);
                            rec_pay[n_tests][8*k +: 8] = v;
                        end
                    end else begin
                        rec_len[n_tests] = int'(f[3]);
                        for (int k = 0; k < 8 && k < rec_len[n_tests]; k++)
                            rec_pay[n_tests][8*k +: 8] = f[6 + k];
                    end
                    n_tests++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic send_host_byte(input mac_byte_t b);
        while (!xrdy)
            next_cycle();
        host_data = b;
        xvalid    = 1'b1;
        next_cycle();
        xvalid    = 1'b0;
    endtask

    task automatic run_test(input int i);
        logic no_ack;
        no_ack      = (rec_ftype[i] == `MAC_FT_ACKREQ) && !rec_ack[i] && rec_kind[i] != 8'd1;
        test_id     = i + 1;
        exp_dest    = rec_dest[i];
        exp_ftype   = (rec_kind[i] == 8'd1) ? `MAC_FT_ACK : rec_ftype[i];
        exp_len     = (rec_kind[i] == 8'd1) ? 0 : rec_len[i];
        exp_payload = rec_pay[i];
        exp_sends   = no_ack ? `MAC_MAX_ATTEMPTS + 1 : 1;
        exp_err_inc = no_ack ? 8'd1 : 8'd0;
        exp_acks    = (rec_kind[i] == 8'd1) ? 1 : 0;
        cardet       = rec_busy[i];
        ack_received = rec_ack[i];
        rdy_random   = (rec_kind[i] == 8'd2);
        test_start   = 1'b1;
        next_cycle();
        test_start   = 1'b0;
        if (rec_kind[i] == 8'd1) begin
            // request held until the ack frame is out
            ack_frame_addr = rec_dest[i];
            ack_needed     = 1'b1;
            while (!ack_sent)
                next_cycle();
            ack_needed     = 1'b0;
        end else begin
            send_host_byte(rec_dest[i]);
            send_host_byte(rec_ftype[i]);
            for (int k = 0; k < rec_len[i]; k++)
                send_host_byte(rec_pay[i][8*k +: 8]);
            xsend = 1'b1;
            next_cycle();
            xsend = 1'b0;
        end
        // busy carrier outlasts the DIFS so the backoff runs
        if (rec_busy[i]) begin
            repeat (HOLD_BUSY)
                next_cycle();
            cardet = 1'b0;
        end
        while (xbusy)
            next_cycle();
        rdy_random = 1'b0;
        repeat (4)
            next_cycle();
        test_end = 1'b1;
        next_cycle();
        test_end = 1'b0;
    endtask

    initial begin
        wait (budget > 0);
        repeat (budget)
            @(posedge clk);
        $display("timeout after %0d cycles, tests did not finish", budget);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        tick_slot      = 1'b0;
        tick_tx        = 1'b0;
        host_data      = 8'h00;
        xvalid         = 1'b0;
        xsend          = 1'b0;
        mx_rdy         = 1'b1;
        cardet         = 1'b0;
        ack_received   = 1'b0;
        ack_needed     = 1'b0;
        ack_frame_addr = 8'h00;
        mac_addr       = 8'h4d;
        test_start     = 1'b0;
        test_end       = 1'b0;
        test_id        = 0;
        exp_dest       = 8'h00;
        exp_ftype      = 8'h00;
        exp_len        = 0;
        exp_payload    = '0;
        exp_sends      = 0;
        exp_acks       = 0;
        exp_err_inc    = 8'h00;
        rdy_random     = 1'b0;
        n_tests        = 0;
        tb_errors      = 0;
        cyc            = 0;
        lfsr           = 16'd31321;
        read_records();
        budget = 2000 + 16;
        for (int i = 0; i < n_tests; i++)
            budget += (`MAC_PREAMBLE_LEN + 4 + rec_len[i]) * 8 + `MAC_MAX_ATTEMPTS
                * (`MAC_ACK_TIMEOUT + `MAC_DIFS_TICKS + BACKOFF_MAX) * 4;
        repeat (16)
            @(posedge clk);
        #2;
        check_reset_level("mx_valid", mx_valid, 1'b0);
        check_reset_level("xbusy", xbusy, 1'b0);
        check_reset_level("ack_sent", ack_sent, 1'b0);
        check_reset_level("xrdy", xrdy, 1'b1);
        if (xerrcnt !== 8'h00) begin
            $display("** Error xerrcnt: expected 00 got %h", xerrcnt);
            tb_errors++;
        end
        rst = 1'b0;
        for (int i = 0; i < n_tests; i++)
            run_test(i);
        next_cycle();
        $display("tests run %0d of %0d, failed %0d, errors %0d", tests_done, n_tests,
            tests_failed, error_total + tb_errors);
        if (n_tests > 0 && tests_done == n_tests && tests_failed == 0 && error_total == 0
                && tb_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+hdl
hdl/mac_pkg.sv
hdl/frame_buffer.sv
hdl/frame_mux.sv
hdl/crc_gen.sv
hdl/xmit_controller.sv
hdl/mac_xmit.sv
test/xmit_checker.sv
test/tb_mac_xmit.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mac_xmit
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'Testbench passed'

clean:
	rm -rf $(OBJ_DIR)

//--- test/xmit_input.txt
# kind dest type len busy ack p0 p1 p2 p3 p4 p5 p6 p7, all hex
# kind 0 host frame, 1 ack frame to dest, 2 host frame with random mx_rdy; len ff = LFSR length and payload
0 a1 31 05 0 0 11 22 33 44 55 00 00 00
0 a2 30 03 0 0 de ad be 00 00 00 00 00
0 a3 31 04 1 0 01 02 03 04 00 00 00 00
0 a4 32 02 0 1 c0 c1 00 00 00 00 00 00
0 a5 32 01 0 0 ee 00 00 00 00 00 00 00
1 b7 33 00 0 0 00 00 00 00 00 00 00 00
2 a6 31 ff 0 0 00 00 00 00 00 00 00 00
